/* Makefile */
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -j 0
TOP := main_tb
FILE_LIST := verilog.f
BUILD_DIR := obj_dir
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)

/* hdl/backlight_pwm.sv */
module backlight_pwm #(
	parameter int PWM_PERIOD = 255
) (
	input  logic       cclk,
	input  logic       reset,
	input  logic [7:0] duty_cycle,
	output logic       backlight
);

	localparam int CNT_W = (PWM_PERIOD > 0) ? $clog2(PWM_PERIOD + 1) : 1;

	logic [CNT_W-1:0] count;

	always_ff @(posedge cclk) begin
		if (reset) begin
			count <= '0;
			backlight <= 1'b0;
		end else begin
			// period of PWM_PERIOD + 1 cycles
			count <= (count == CNT_W'(PWM_PERIOD)) ? '0 : count + 1'b1;
			// high for duty_cycle counts each period
			backlight <= (32'(count) < 32'(duty_cycle));
		end
	end

endmodule

/* hdl/main.sv */
module main #(
	parameter int H_ACTIVE = tft_touch_pkg::DEFAULT_H_ACTIVE,
	parameter int H_TOTAL = tft_touch_pkg::DEFAULT_H_TOTAL,
	parameter int V_ACTIVE = tft_touch_pkg::DEFAULT_V_ACTIVE,
	parameter int V_TOTAL = tft_touch_pkg::DEFAULT_V_TOTAL,
	parameter int TOUCH_CLK_DIV = tft_touch_pkg::DEFAULT_TOUCH_CLK_DIV,
	parameter int PWM_PERIOD = tft_touch_pkg::DEFAULT_PWM_PERIOD
) (
	input  logic       cclk,
	input  logic       reset,
	input  logic [7:0] switch,
	input  logic       touch_busy,
	input  logic       touch_data_out,
	output logic       touch_csb,
	output logic       touch_clk,
	output logic       touch_data_in,
	output logic [7:0] tft_red,
	output logic [7:0] tft_green,
	output logic [7:0] tft_blue,
	output logic       tft_data_ena,
	output logic       tft_display,
	output logic       tft_vdd,
	output logic       tft_backlight
);

	// touch path
	logic                         sclk_enable;
	logic                         sclk_rise;
	logic                         sclk_fall;
	logic                         bit_done;
	logic [4:0]                   transfer_bits;
	logic                         shift_load;
	logic                         capture;
	tft_touch_pkg::touch_cmd_e    command;
	tft_touch_pkg::touch_sample_t sample;
	// scan path
	tft_touch_pkg::scan_pos_t     pos;
	tft_touch_pkg::rgb_t          pixel;
	logic                         power_on;

	touch_sequencer u_touch_sequencer (
		.cclk(cclk), .reset(reset), .bit_done(bit_done), .csb(touch_csb),
		.sclk_enable(sclk_enable), .transfer_bits(transfer_bits),
		.shift_load(shift_load), .command(command), .capture(capture)
	);

	touch_bit_timer #(.TOUCH_CLK_DIV(TOUCH_CLK_DIV)) u_touch_bit_timer (
		.cclk(cclk), .reset(reset), .sclk_enable(sclk_enable),
		.transfer_bits(transfer_bits), .touch_clk(touch_clk),
		.sclk_rise(sclk_rise), .sclk_fall(sclk_fall), .bit_done(bit_done)
	);

	// converter DOUT feeds the shifter, shifter feeds converter DIN
	touch_shift_unit u_touch_shift_unit (
		.cclk(cclk), .reset(reset), .shift_load(shift_load), .command(command),
		.capture(capture), .sclk_rise(sclk_rise), .sclk_fall(sclk_fall),
		.data_in(touch_data_out), .data_out(touch_data_in), .sample(sample)
	);

	tft_scan_timer #(
		.H_ACTIVE(H_ACTIVE), .H_TOTAL(H_TOTAL), .V_ACTIVE(V_ACTIVE), .V_TOTAL(V_TOTAL)
	) u_tft_scan_timer (
		.cclk(cclk), .reset(reset), .pos(pos)
	);

	tft_pixel_render u_tft_pixel_render (
		.cclk(cclk), .reset(reset), .pos(pos), .sample(sample),
		.pixel(pixel), .data_ena(tft_data_ena)
	);

	// switches set the dimming level
	backlight_pwm #(.PWM_PERIOD(PWM_PERIOD)) u_backlight_pwm (
		.cclk(cclk), .reset(reset), .duty_cycle(switch), .backlight(tft_backlight)
	);

	// panel supply and display enable come up once reset is gone
	always_ff @(posedge cclk) begin
		if (reset)
			power_on <= 1'b0;
		else
			power_on <= 1'b1;
	end

	assign tft_vdd = power_on;
	assign tft_display = power_on;
	assign tft_red = pixel.red;
	assign tft_green = pixel.green;
	assign tft_blue = pixel.blue;

	// converter only reports busy inside a conversation
	busy_only_selected: assert property (@(posedge cclk) disable iff (reset)
		touch_csb |-> !touch_busy);

endmodule

/* hdl/tft_pixel_render.sv */
module tft_pixel_render (
	input  logic                         cclk,
	input  logic                         reset,
	input  tft_touch_pkg::scan_pos_t     pos,
	input  tft_touch_pkg::touch_sample_t sample,
	output tft_touch_pkg::rgb_t          pixel,
	output logic                         data_ena
);

	tft_touch_pkg::cursor_t cursor;
	logic [11:0]            offset_x;
	logic [11:0]            offset_y;
	logic                   pressed;
	logic                   on_cursor;

	// calibration offsets, kept at 12 bits
	assign offset_x = sample.x - 12'(tft_touch_pkg::TOUCH_OFFSET_X);
	assign offset_y = sample.y - 12'(tft_touch_pkg::TOUCH_OFFSET_Y);
	// light touches are ignored
	assign pressed = (sample.z >= 12'(tft_touch_pkg::PRESS_LIMIT));

	// cursor only moves between frames
	always_ff @(posedge cclk) begin
		if (reset) begin
			cursor <= '0;
		end else if (pos.new_frame && pressed) begin
			// four touch counts per pixel
			cursor.x <= offset_x >> 2;
			cursor.y <= offset_y >> 2;
		end
	end

	// crosshair lines through the cursor
	assign on_cursor = ({2'b00, pos.x} == cursor.x) || ({3'b000, pos.y} == cursor.y);

	// one cycle behind the scan position
	always_ff @(posedge cclk) begin
		if (reset) begin
			pixel <= '0;
			data_ena <= 1'b0;
		end else if (pos.active) begin
			data_ena <= 1'b1;
			pixel <= on_cursor ? tft_touch_pkg::CURSOR_COLOR :
				tft_touch_pkg::BACKGROUND_COLOR;
		end else begin
			// black during blanking
			data_ena <= 1'b0;
			pixel <= '0;
		end
	end

endmodule

/* hdl/tft_scan_timer.sv */
module tft_scan_timer #(
	parameter int H_ACTIVE = 480,
	parameter int H_TOTAL = 525,
	parameter int V_ACTIVE = 272,
	parameter int V_TOTAL = 286
) (
	input  logic                     cclk,
	input  logic                     reset,
	output tft_touch_pkg::scan_pos_t pos
);

	logic [9:0] h_cnt;
	logic [8:0] v_cnt;
	logic       h_end;
	logic       v_end;

	// last column of a line, last line of a frame
	assign h_end = (h_cnt == 10'(H_TOTAL - 1));
	assign v_end = (v_cnt == 9'(V_TOTAL - 1));

	always_ff @(posedge cclk) begin
		if (reset) begin
			h_cnt <= 10'd0;
			v_cnt <= 9'd0;
		end else if (h_end) begin
			h_cnt <= 10'd0;
			// line wrap steps the row counter
			v_cnt <= v_end ? 9'd0 : v_cnt + 9'd1;
		end else begin
			h_cnt <= h_cnt + 10'd1;
		end
	end

	assign pos.x = h_cnt;
	assign pos.y = v_cnt;
	// blanking lies past the active area on both axes
	assign pos.active = (h_cnt < 10'(H_ACTIVE)) && (v_cnt < 9'(V_ACTIVE));
	// single cycle on the final count of the frame
	assign pos.new_frame = h_end && v_end;

	h_cnt_in_range: assert property (@(posedge cclk) disable iff (reset)
		h_cnt < 10'(H_TOTAL));

endmodule

/* hdl/tft_touch_pkg.sv */
package tft_touch_pkg;

	// converter control bytes, start bit plus channel select
	typedef enum logic [7:0] {
		cmd_x  = 8'hd0,
		cmd_y  = 8'h90,
		cmd_z1 = 8'hb0
	} touch_cmd_e;

	// one converter conversation per channel
	typedef enum logic [2:0] {
		st_idle,
		st_select,
		st_command,
		st_receive,
		st_release
	} touch_state_e;

	// raw 12 bit readings
	typedef struct packed {
		logic [11:0] x;
		logic [11:0] y;
		logic [11:0] z;
	} touch_sample_t;

	typedef struct packed {
		logic [9:0] x;
		logic [8:0] y;
		logic       active;
		logic       new_frame;
	} scan_pos_t;

	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} rgb_t;

	// latched crosshair position in panel pixels
	typedef struct packed {
		logic [11:0] x;
		logic [11:0] y;
	} cursor_t;

	// 480x272 panel timing
	localparam int DEFAULT_H_ACTIVE = 480;
	localparam int DEFAULT_H_TOTAL = 525;
	localparam int DEFAULT_V_ACTIVE = 272;
	localparam int DEFAULT_V_TOTAL = 286;
	// serial clock and backlight defaults
	localparam int DEFAULT_TOUCH_CLK_DIV = 32;
	localparam int DEFAULT_PWM_PERIOD = 255;

	// touch calibration
	localparam int TOUCH_OFFSET_X = 150;
	localparam int TOUCH_OFFSET_Y = 300;
	localparam int PRESS_LIMIT = 256;

	localparam rgb_t CURSOR_COLOR = '{red: 8'hff, green: 8'hff, blue: 8'hff};
	localparam rgb_t BACKGROUND_COLOR = '{red: 8'h00, green: 8'h00, blue: 8'hff};

endpackage

/* hdl/touch_bit_timer.sv */
module touch_bit_timer #(
	parameter int TOUCH_CLK_DIV = 32
) (
	input  logic       cclk,
	input  logic       reset,
	input  logic       sclk_enable,
	input  logic [4:0] transfer_bits,
	output logic       touch_clk,
	output logic       sclk_rise,
	output logic       sclk_fall,
	output logic       bit_done
);

	localparam int DIV_W = (TOUCH_CLK_DIV > 1) ? $clog2(TOUCH_CLK_DIV) : 1;

	logic [DIV_W-1:0] div_cnt;
	logic [4:0]       bit_cnt;
	logic             div_end;

	// half a serial period elapsed
	assign div_end = (div_cnt == DIV_W'(TOUCH_CLK_DIV - 1));

	// strobes mark the cclk edge where touch_clk toggles
	assign sclk_rise = sclk_enable && div_end && !touch_clk;
	assign sclk_fall = sclk_enable && div_end && touch_clk;
	assign bit_done = sclk_rise && (bit_cnt == transfer_bits - 5'd1);

	always_ff @(posedge cclk) begin
		if (reset || !sclk_enable) begin
			// serial clock parks low between transfers
			div_cnt <= '0;
			touch_clk <= 1'b0;
			bit_cnt <= 5'd0;
		end else begin
			if (div_end) begin
				div_cnt <= '0;
				touch_clk <= !touch_clk;
			end else begin
				div_cnt <= div_cnt + 1'b1;
			end
			// count rising edges within the current phase
			if (sclk_rise)
				bit_cnt <= bit_done ? 5'd0 : bit_cnt + 5'd1;
		end
	end

	// phase length comes from the sequencer
	bit_cnt_in_range: assert property (@(posedge cclk) disable iff (reset)
		sclk_enable |-> (bit_cnt < transfer_bits));

endmodule

/* hdl/touch_sequencer.sv */
module touch_sequencer (
	input  logic                      cclk,
	input  logic                      reset,
	input  logic                      bit_done,
	output logic                      csb,
	output logic                      sclk_enable,
	output logic [4:0]                transfer_bits,
	output logic                      shift_load,
	output tft_touch_pkg::touch_cmd_e command,
	output logic                      capture
);

	tft_touch_pkg::touch_state_e state;
	tft_touch_pkg::touch_state_e state_next;

	// next state
	always_comb begin
		state_next = state;
		case (state)
			tft_touch_pkg::st_idle: state_next = tft_touch_pkg::st_select;
			tft_touch_pkg::st_select: state_next = tft_touch_pkg::st_command;
			tft_touch_pkg::st_command: begin
				// control byte fully clocked out
				if (bit_done)
					state_next = tft_touch_pkg::st_receive;
			end
			tft_touch_pkg::st_receive: begin
				// all 16 result bits clocked in
				if (bit_done)
					state_next = tft_touch_pkg::st_release;
			end
			tft_touch_pkg::st_release: state_next = tft_touch_pkg::st_idle;
			default: state_next = tft_touch_pkg::st_idle;
		endcase
	end

	always_ff @(posedge cclk) begin
		if (reset) begin
			state <= tft_touch_pkg::st_idle;
			csb <= 1'b1;
			command <= tft_touch_pkg::cmd_x;
			capture <= 1'b0;
		end else begin
			state <= state_next;
			// last result bit lands in the shifter on this edge
			capture <= (state == tft_touch_pkg::st_receive) && bit_done;
			// chip select low from select through release
			if (state == tft_touch_pkg::st_idle)
				csb <= 1'b0;
			if (state == tft_touch_pkg::st_release) begin
				csb <= 1'b1;
				// round robin X, Y, Z1
				case (command)
					tft_touch_pkg::cmd_x: command <= tft_touch_pkg::cmd_y;
					tft_touch_pkg::cmd_y: command <= tft_touch_pkg::cmd_z1;
					default: command <= tft_touch_pkg::cmd_x;
				endcase
			end
		end
	end

	// load the control byte while chip select settles
	assign shift_load = (state == tft_touch_pkg::st_select);
	// serial clock runs straight through command and receive
	assign sclk_enable = (state == tft_touch_pkg::st_command) ||
		(state == tft_touch_pkg::st_receive);
	// 8 command bits, then 12 data bits plus 4 trailing zeros
	assign transfer_bits = (state == tft_touch_pkg::st_command) ? 5'd8 : 5'd16;

	// converter deselected between conversations
	csb_idle_high: assert property (@(posedge cclk) disable iff (reset)
		(state == tft_touch_pkg::st_idle) |-> csb);

endmodule

/* hdl/touch_shift_unit.sv */
module touch_shift_unit (
	input  logic                         cclk,
	input  logic                         reset,
	input  logic                         shift_load,
	input  tft_touch_pkg::touch_cmd_e    command,
	input  logic                         capture,
	input  logic                         sclk_rise,
	input  logic                         sclk_fall,
	input  logic                         data_in,
	output logic                         data_out,
	output tft_touch_pkg::touch_sample_t sample
);

	logic [7:0]  cmd_shift;
	logic [15:0] result_shift;

	// outgoing control byte, MSB first
	always_ff @(posedge cclk) begin
		if (reset)
			cmd_shift <= 8'd0;
		else if (shift_load)
			cmd_shift <= command;
		else if (sclk_fall)
			// next bit on the falling edge, zeros once the byte is out
			cmd_shift <= {cmd_shift[6:0], 1'b0};
	end

	assign data_out = cmd_shift[7];

	// incoming bits sampled on the rising edge
	// command phase bits fall off the top during receive
	always_ff @(posedge cclk) begin
		if (sclk_rise)
			result_shift <= {result_shift[14:0], data_in};
	end

	// 12 data bits sit above the 4 trailing zeros
	always_ff @(posedge cclk) begin
		if (reset) begin
			sample <= '0;
		end else if (capture) begin
			case (command)
				tft_touch_pkg::cmd_x: sample.x <= result_shift[15:4];
				tft_touch_pkg::cmd_y: sample.y <= result_shift[15:4];
				tft_touch_pkg::cmd_z1: sample.z <= result_shift[15:4];
				default: sample <= sample;
			endcase
		end
	end

endmodule

/* verification/main_tb.sv */
module main_tb;
	timeunit 1ns;
	timeprecision 1ps;

	// small frame keeps the run short
	localparam int H_ACTIVE = 16;
	localparam int H_TOTAL = 20;
	localparam int V_ACTIVE = 8;
	localparam int V_TOTAL = 10;
	localparam int TOUCH_CLK_DIV = 2;
	localparam int PWM_PERIOD = 255;
	localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
	localparam int CMD_TIMEOUT = 400;
	localparam int FRAME_TIMEOUT = 2 * FRAME_CYCLES;
	// a press inside the calibrated area and a light touch elsewhere
	localparam int PRESS_X = 170;
	localparam int PRESS_Y = 320;
	localparam int PRESS_Z = 1000;
	localparam int LIGHT_X = 600;
	localparam int LIGHT_Y = 700;
	localparam int LIGHT_Z = 100;

	logic                      cclk;
	logic                      reset;
	logic [7:0]                switch;
	logic                      touch_busy;
	logic                      touch_data_out;
	logic                      touch_csb;
	logic                      touch_clk;
	logic                      touch_data_in;
	logic [7:0]                tft_red;
	logic [7:0]                tft_green;
	logic [7:0]                tft_blue;
	logic                      tft_data_ena;
	logic                      tft_display;
	logic                      tft_vdd;
	logic                      tft_backlight;
	logic [11:0]               touch_x;
	logic [11:0]               touch_y;
	logic [11:0]               touch_z;
	int                        cmd_count;
	tft_touch_pkg::touch_cmd_e last_cmd;
	logic [31:0]               rng_state;
	int                        cursor_x;
	int                        cursor_y;

	main #(
		.H_ACTIVE(H_ACTIVE), .H_TOTAL(H_TOTAL), .V_ACTIVE(V_ACTIVE), .V_TOTAL(V_TOTAL),
		.TOUCH_CLK_DIV(TOUCH_CLK_DIV), .PWM_PERIOD(PWM_PERIOD)
	) u_main (
		.cclk(cclk), .reset(reset), .switch(switch), .touch_busy(touch_busy),
		.touch_data_out(touch_data_out), .touch_csb(touch_csb), .touch_clk(touch_clk),
		.touch_data_in(touch_data_in), .tft_red(tft_red), .tft_green(tft_green),
		.tft_blue(tft_blue), .tft_data_ena(tft_data_ena), .tft_display(tft_display),
		.tft_vdd(tft_vdd), .tft_backlight(tft_backlight)
	);

	// converter side of the serial link
	touch_panel_model u_touch_panel_model (
		.csb(touch_csb), .sclk(touch_clk), .din(touch_data_in),
		.x_value(touch_x), .y_value(touch_y), .z_value(touch_z),
		.dout(touch_data_out), .busy(touch_busy),
		.cmd_count(cmd_count), .last_cmd(last_cmd)
	);

	initial begin
		cclk = 1'b0;
		forever #2 cclk = ~cclk;
	end

	task automatic stop_with_failure();
		$display("Simulation finished: FAIL");
		$fatal(1, "stopped at the first failure");
	endtask

	task automatic compare_rgb(input string name, input tft_touch_pkg::rgb_t got,
		input tft_touch_pkg::rgb_t exp);
		if (got !== exp) begin
			$display("[ERROR] %0t ns %s: expected %h, got %h", $time, name, exp, got);
			stop_with_failure();
		end
	endtask

	task automatic compare_cmd(input string name, input tft_touch_pkg::touch_cmd_e got,
		input tft_touch_pkg::touch_cmd_e exp);
		if (got !== exp) begin
			$display("[ERROR] %0t ns %s: expected %s (%h), got %s (%h)", $time, name,
				exp.name(), exp, got.name(), got);
			stop_with_failure();
		end
	endtask

	task automatic compare_count(input string name, input int got, input int exp);
		if (got !== exp) begin
			$display("[ERROR] %0t ns %s: expected %0d, got %0d", $time, name, exp, got);
			stop_with_failure();
		end
	endtask

	// 32 bit xorshift with shifts of 13, 17 and 5
	function automatic logic [31:0] xorshift32(input logic [31:0] state);
		logic [31:0] s;
		s = state;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	// next control byte decoded by the converter
	task automatic wait_for_command();
		int start;
		int cycles;
		start = cmd_count;
		cycles = 0;
		while (cmd_count == start && cycles < CMD_TIMEOUT) begin
			@(negedge cclk);
			cycles++;
		end
		if (cmd_count == start) begin
			$display("Timed out waiting for the touch controller to send a command");
			stop_with_failure();
		end
	endtask

	// stops on the last count of a frame and never on the same one twice
	task automatic wait_new_frame();
		int cycles;
		cycles = 0;
		do begin
			@(negedge cclk);
			cycles++;
		end while (!u_main.pos.new_frame && cycles < FRAME_TIMEOUT);
		if (!u_main.pos.new_frame) begin
			$display("Timed out waiting for the end of a frame");
			stop_with_failure();
		end
	endtask

	// checks every pixel of the next frame against a crosshair at cur_x and cur_y
	task automatic scan_frame(input int cur_x, input int cur_y, output int ena_count);
		int i;
		int col;
		int row;
		tft_touch_pkg::rgb_t expected;
		wait_new_frame();
		// output register still holds the last blanking pixel
		@(negedge cclk);
		ena_count = 0;
		for (i = 0; i < FRAME_CYCLES; i++) begin
			@(negedge cclk);
			col = i % H_TOTAL;
			row = i / H_TOTAL;
			if (tft_data_ena)
				ena_count++;
			if (col < H_ACTIVE && row < V_ACTIVE) begin
				if (col == cur_x || row == cur_y)
					expected = tft_touch_pkg::CURSOR_COLOR;
				else
					expected = tft_touch_pkg::BACKGROUND_COLOR;
				compare_count("tft_data_ena", int'(tft_data_ena), 1);
			end else begin
				expected = '0;
				compare_count("tft_data_ena", int'(tft_data_ena), 0);
			end
			compare_rgb("tft_rgb", {tft_red, tft_green, tft_blue}, expected);
		end
	endtask

	task automatic verify_reset_state();
		repeat (2) @(posedge cclk);
		reset <= 1'b0;
		@(negedge cclk);
		compare_count("touch_csb", int'(touch_csb), 1);
		compare_count("touch_clk", int'(touch_clk), 0);
		compare_count("touch_data_in", int'(touch_data_in), 0);
		compare_count("tft_data_ena", int'(tft_data_ena), 0);
		compare_count("tft_backlight", int'(tft_backlight), 0);
		compare_count("tft_vdd", int'(tft_vdd), 0);
		// supply comes up one cycle later
		@(negedge cclk);
		compare_count("tft_vdd", int'(tft_vdd), 1);
		compare_count("tft_display", int'(tft_display), 1);
	endtask

	task automatic follow_command_order();
		tft_touch_pkg::touch_cmd_e order[3];
		int i;
		order[0] = tft_touch_pkg::cmd_x;
		order[1] = tft_touch_pkg::cmd_y;
		order[2] = tft_touch_pkg::cmd_z1;
		compare_count("cmd_count", cmd_count, 0);
		for (i = 0; i < 6; i++) begin
			wait_for_command();
			compare_cmd("last_cmd", last_cmd, order[i % 3]);
		end
	endtask

	// no press yet so the crosshair sits at the origin
	task automatic count_active_area();
		int ena_count;
		scan_frame(0, 0, ena_count);
		compare_count("tft_data_ena high cycles", ena_count, H_ACTIVE * V_ACTIVE);
	endtask

	task automatic draw_crosshair();
		int ena_count;
		@(posedge cclk);
		touch_x <= 12'(PRESS_X);
		touch_y <= 12'(PRESS_Y);
		touch_z <= 12'(PRESS_Z);
		// offset removed and four counts per pixel
		cursor_x = (PRESS_X - tft_touch_pkg::TOUCH_OFFSET_X) / 4;
		cursor_y = (PRESS_Y - tft_touch_pkg::TOUCH_OFFSET_Y) / 4;
		repeat (6) wait_for_command();
		repeat (2) wait_new_frame();
		scan_frame(cursor_x, cursor_y, ena_count);
	endtask

	task automatic release_touch();
		int ena_count;
		// pressure drops first so the moved x and y never pair with a press
		@(posedge cclk);
		touch_z <= 12'(LIGHT_Z);
		repeat (4) wait_for_command();
		@(posedge cclk);
		touch_x <= 12'(LIGHT_X);
		touch_y <= 12'(LIGHT_Y);
		repeat (6) wait_for_command();
		repeat (3) wait_new_frame();
		scan_frame(cursor_x, cursor_y, ena_count);
	endtask

	task automatic sweep_backlight();
		int duties[4];
		int high_count;
		int i;
		int k;
		duties[0] = 0;
		for (i = 1; i < 4; i++) begin
			rng_state = xorshift32(rng_state);
			duties[i] = int'(rng_state[7:0]);
		end
		for (i = 0; i < 4; i++) begin
			@(posedge cclk);
			switch <= 8'(duties[i]);
			// first sample after the change still shows the old duty
			@(negedge cclk);
			high_count = 0;
			for (k = 0; k < PWM_PERIOD + 1; k++) begin
				@(negedge cclk);
				if (tft_backlight)
					high_count++;
			end
			compare_count("tft_backlight high cycles", high_count, duties[i]);
		end
	endtask

	initial begin
		reset <= 1'b1;
		switch <= 8'd0;
		touch_x <= 12'd0;
		touch_y <= 12'd0;
		touch_z <= 12'd0;
		rng_state = 32'd21811;
		cursor_x = 0;
		cursor_y = 0;
		verify_reset_state();
		follow_command_order();
		count_active_area();
		draw_crosshair();
		release_touch();
		sweep_backlight();
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

/* verification/touch_panel_model.sv */
module touch_panel_model (
	input  logic                      csb,
	input  logic                      sclk,
	input  logic                      din,
	input  logic [11:0]               x_value,
	input  logic [11:0]               y_value,
	input  logic [11:0]               z_value,
	output logic                      dout,
	output logic                      busy,
	output int                        cmd_count,
	output tft_touch_pkg::touch_cmd_e last_cmd
);
	timeunit 1ns;
	timeprecision 1ps;

	logic [7:0]                cmd_byte = 8'd0;
	logic [11:0]               reply = 12'd0;
	logic                      dout_q = 1'b0;
	logic                      busy_q = 1'b0;
	int                        rise_cnt = 0;
	int                        count_q = 0;
	tft_touch_pkg::touch_cmd_e cmd_q = tft_touch_pkg::cmd_x;

	// busy for one serial clock while the conversion runs
	assign busy = busy_q;
	assign dout = dout_q;
	assign cmd_count = count_q;
	assign last_cmd = cmd_q;

	// control byte sampled MSB first on rising serial edges
	always @(posedge sclk or posedge csb) begin
		if (csb) begin
			rise_cnt = 0;
		end else begin
			if (rise_cnt < 8)
				cmd_byte = {cmd_byte[6:0], din};
			rise_cnt = rise_cnt + 1;
			if (rise_cnt == 8) begin
				cmd_q = tft_touch_pkg::touch_cmd_e'(cmd_byte);
				count_q = count_q + 1;
				// reading is fixed for the rest of the conversation
				case (tft_touch_pkg::touch_cmd_e'(cmd_byte))
					tft_touch_pkg::cmd_x: reply = x_value;
					tft_touch_pkg::cmd_y: reply = y_value;
					tft_touch_pkg::cmd_z1: reply = z_value;
					default: reply = 12'd0;
				endcase
			end
		end
	end

	// 12 result bits on falling edges after the command and zeros after them
	always @(negedge sclk) begin
		if (!csb && rise_cnt >= 8 && rise_cnt < 20)
			dout_q = reply[4'(19 - rise_cnt)];
		else
			dout_q = 1'b0;
		// stays up if chip select rises in the middle of a conversion
		busy_q = !csb && (rise_cnt == 8);
	end

endmodule

/* verilog.f */
hdl/tft_touch_pkg.sv
hdl/touch_sequencer.sv
hdl/touch_bit_timer.sv
hdl/touch_shift_unit.sv
hdl/tft_scan_timer.sv
hdl/tft_pixel_render.sv
hdl/backlight_pwm.sv
hdl/main.sv
verification/touch_panel_model.sv
verification/main_tb.sv
